// File: build.f
+incdir+bench
design/rs_alu_pkg.sv
design/operand_wakeup.sv
design/rs_alu_entry.sv
design/rs_busy_tracker.sv
design/rs_alu.sv
bench/rs_alu_tb.sv

// File: bench/rs_alu_ref.svh
`ifndef RS_ALU_REF_SVH
`define RS_ALU_REF_SVH

// Station model, advanced once per rising edge
ent_vec_t   m_busy;
logic       m_v1 [ENT_NUM];
logic       m_v2 [ENT_NUM];
data_t      m_src1 [ENT_NUM];   // Value when valid, tag in low bits otherwise
data_t      m_src2 [ENT_NUM];
addr_t      m_pc [ENT_NUM];
data_t      m_imm [ENT_NUM];
rrf_tag_t   m_rrftag [ENT_NUM];
logic       m_dstval [ENT_NUM];
src_a_sel_t m_src_a [ENT_NUM];
src_b_sel_t m_src_b [ENT_NUM];
alu_op_t    m_alu_op [ENT_NUM];

function automatic ent_vec_t expected_ready();
   ent_vec_t r;
   for (int i = 0; i < ENT_NUM; i++) begin
      r[i] = m_busy[i] & m_v1[i] & m_v2[i];
   end
   return r;
endfunction

// Lowest-numbered valid bus carrying the tag, -1 if none
function automatic int matching_bus(rrf_tag_t tag);
   for (int b = 0; b < CDB_NUM; b++) begin
      if (exvalid[b] && (exdst[b] == tag))
         return b;
   end
   return -1;
endfunction

function automatic void model_reset();
   m_busy = '0;
   for (int i = 0; i < ENT_NUM; i++) begin
      m_v1[i] = 1'b0;
      m_v2[i] = 1'b0;
   end
endfunction

function automatic void load_entry(ent_sel_t a, addr_t p, data_t s1, data_t s2, logic v1,
                                   logic v2, data_t im, rrf_tag_t t, logic dv,
                                   src_a_sel_t sa, src_b_sel_t sb, alu_op_t op);
   m_busy[a]   = 1'b1;
   m_pc[a]     = p;
   m_src1[a]   = s1;
   m_src2[a]   = s2;
   m_v1[a]     = v1;
   m_v2[a]     = v2;
   m_imm[a]    = im;
   m_rrftag[a] = t;
   m_dstval[a] = dv;
   m_src_a[a]  = sa;
   m_src_b[a]  = sb;
   m_alu_op[a] = op;
endfunction

function automatic void model_clock();
   int b;
   for (int i = 0; i < ENT_NUM; i++) begin
      b = matching_bus(m_src1[i][RRF_SEL-1:0]);
      if (!m_v1[i] && b >= 0) begin
         m_src1[i] = exrslt[b];
         m_v1[i]   = 1'b1;
      end
      b = matching_bus(m_src2[i][RRF_SEL-1:0]);
      if (!m_v2[i] && b >= 0) begin
         m_src2[i] = exrslt[b];
         m_v2[i]   = 1'b1;
      end
   end
   if (clearbusy)
      m_busy[issueaddr] = 1'b0;
   // Port 1 applied last so it wins
   if (we2)
      load_entry(waddr2, wpc_2, wsrc1_2, wsrc2_2, wvalid1_2, wvalid2_2, wimm_2, wrrftag_2,
                 wdstval_2, wsrc_a_2, wsrc_b_2, walu_op_2);
   if (we1)
      load_entry(waddr1, wpc_1, wsrc1_1, wsrc2_1, wvalid1_1, wvalid2_1, wimm_1, wrrftag_1,
                 wdstval_1, wsrc_a_1, wsrc_b_1, walu_op_1);
endfunction

`endif

// File: bench/rs_alu_tb.sv
`timescale 1ns/10ps

module rs_alu_tb
   import rs_alu_pkg::*;
();

   localparam int RESET_CYCLES    = 10;
   localparam int DIRECTED_CYCLES = 20;
   localparam int RANDOM_CYCLES   = 400;
   localparam int CYCLE_LIMIT     = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 50;

   logic       clk;
   logic       reset;
   logic       we1, we2;
   ent_sel_t   waddr1, waddr2;
   addr_t      wpc_1, wpc_2;
   data_t      wsrc1_1, wsrc2_1, wsrc1_2, wsrc2_2;
   logic       wvalid1_1, wvalid2_1, wvalid1_2, wvalid2_2;
   data_t      wimm_1, wimm_2;
   rrf_tag_t   wrrftag_1, wrrftag_2;
   logic       wdstval_1, wdstval_2;
   src_a_sel_t wsrc_a_1, wsrc_a_2;
   src_b_sel_t wsrc_b_1, wsrc_b_2;
   alu_op_t    walu_op_1, walu_op_2;
   logic       clearbusy;
   ent_sel_t   issueaddr;
   data_t      exrslt [CDB_NUM];
   rrf_tag_t   exdst [CDB_NUM];
   logic       exvalid [CDB_NUM];
   ent_vec_t   busyvec, ready;
   data_t      ex_src1, ex_src2, imm;
   addr_t      pc;
   rrf_tag_t   rrftag;
   logic       dstval;
   src_a_sel_t src_a;
   src_b_sel_t src_b;
   alu_op_t    alu_op;
   integer     seed = 32'h834a_773a;
   int         cycle_count = 0;

   rs_alu uut (.*);

   `include "rs_alu_ref.svh"

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) begin
      if (reset)
         model_reset();
      else
         model_clock();
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > CYCLE_LIMIT)
         stop_with_failure($sformatf("Run did not finish within %0d cycles", CYCLE_LIMIT));
   end

   task automatic stop_with_failure(string what);
      $display("%s", what);
      $display("Finished with errors");
      $fatal(1, "Stopped at first failure");
   endtask

   task automatic check_vec(string name, ent_vec_t got, ent_vec_t exp);
      if (got !== exp)
         stop_with_failure($sformatf("[ERROR] %0t %s = %h, expected %h", $time, name, got, exp));
   endtask

   task automatic check_data(string name, data_t got, data_t exp);
      if (got !== exp)
         stop_with_failure($sformatf("[ERROR] %0t %s = %h, expected %h", $time, name, got, exp));
   endtask

   task automatic check_addr(string name, addr_t got, addr_t exp);
      if (got !== exp)
         stop_with_failure($sformatf("[ERROR] %0t %s = %h, expected %h", $time, name, got, exp));
   endtask

   task automatic check_tag(string name, rrf_tag_t got, rrf_tag_t exp);
      if (got !== exp)
         stop_with_failure($sformatf("[ERROR] %0t %s = %h, expected %h", $time, name, got, exp));
   endtask

   task automatic check_bit(string name, logic got, logic exp);
      if (got !== exp)
         stop_with_failure($sformatf("[ERROR] %0t %s = %b, expected %b", $time, name, got, exp));
   endtask

   task automatic check_src_a(string name, src_a_sel_t got, src_a_sel_t exp);
      if (got !== exp)
         stop_with_failure($sformatf("[ERROR] %0t %s = %h, expected %h", $time, name, got, exp));
   endtask

   task automatic check_src_b(string name, src_b_sel_t got, src_b_sel_t exp);
      if (got !== exp)
         stop_with_failure($sformatf("[ERROR] %0t %s = %h, expected %h", $time, name, got, exp));
   endtask

   task automatic check_op(string name, alu_op_t got, alu_op_t exp);
      if (got !== exp)
         stop_with_failure($sformatf("[ERROR] %0t %s = %h, expected %h", $time, name, got, exp));
   endtask

   // Compare against the model mid-cycle
   always @(negedge clk) begin
      if (!reset) begin
         check_vec("busyvec", busyvec, m_busy);
         check_vec("ready", ready, expected_ready());
         if (m_busy[issueaddr]) begin
            check_data("ex_src1", ex_src1, m_src1[issueaddr]);
            check_data("ex_src2", ex_src2, m_src2[issueaddr]);
            check_addr("pc", pc, m_pc[issueaddr]);
            check_data("imm", imm, m_imm[issueaddr]);
            check_tag("rrftag", rrftag, m_rrftag[issueaddr]);
            check_bit("dstval", dstval, m_dstval[issueaddr]);
            check_src_a("src_a", src_a, m_src_a[issueaddr]);
            check_src_b("src_b", src_b, m_src_b[issueaddr]);
            check_op("alu_op", alu_op, m_alu_op[issueaddr]);
         end
      end
   end

   // One cycle on, then strobes and broadcasts back to idle
   task automatic step();
      @(posedge clk);
      #1;
      we1       = 1'b0;
      we2       = 1'b0;
      clearbusy = 1'b0;
      for (int b = 0; b < CDB_NUM; b++)
         exvalid[b] = 1'b0;
   endtask

   task automatic alloc(int port, ent_sel_t a, logic v1, logic v2, data_t s1, data_t s2);
      if (port == 1) begin
         we1       = 1'b1;
         waddr1    = a;
         wvalid1_1 = v1;
         wvalid2_1 = v2;
         wsrc1_1   = s1;
         wsrc2_1   = s2;
         wpc_1     = $random(seed);
         wimm_1    = $random(seed);
         wrrftag_1 = $random(seed);
         {wdstval_1, wsrc_a_1, wsrc_b_1, walu_op_1} = $random(seed);
      end else begin
         we2       = 1'b1;
         waddr2    = a;
         wvalid1_2 = v1;
         wvalid2_2 = v2;
         wsrc1_2   = s1;
         wsrc2_2   = s2;
         wpc_2     = $random(seed);
         wimm_2    = $random(seed);
         wrrftag_2 = $random(seed);
         {wdstval_2, wsrc_a_2, wsrc_b_2, walu_op_2} = $random(seed);
      end
   endtask

   task automatic broadcast(int b, rrf_tag_t tag, data_t value, logic valid);
      exdst[b]   = tag;
      exrslt[b]  = value;
      exvalid[b] = valid;
   endtask

   initial begin
      ent_sel_t a;
      data_t    s1;
      data_t    s2;
      logic     v1;
      logic     v2;
      logic     go;
      reset = 1'b1;
      {we1, we2, clearbusy, issueaddr, waddr1, waddr2} = '0;
      {wpc_1, wsrc1_1, wsrc2_1, wvalid1_1, wvalid2_1, wimm_1, wrrftag_1} = '0;
      {wpc_2, wsrc1_2, wsrc2_2, wvalid1_2, wvalid2_2, wimm_2, wrrftag_2} = '0;
      {wdstval_1, wsrc_a_1, wsrc_b_1, walu_op_1, wdstval_2, wsrc_a_2, wsrc_b_2, walu_op_2} = '0;
      for (int b = 0; b < CDB_NUM; b++)
         broadcast(b, '0, '0, 1'b0);
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      reset = 1'b0;
      step();

      alloc(1, 3'd3, 1'b1, 1'b1, 32'h1234_5678, 32'h9abc_def0);
      issueaddr = 3'd3;
      step();
      step();

      // Operand 1 waits on tag 9, buses 2 and 3 both carry it
      alloc(1, 3'd5, 1'b0, 1'b1, 32'hfff0_0009, 32'h0000_0042);
      issueaddr = 3'd5;
      step();
      step();
      broadcast(0, 6'd9, 32'h0bad_0bad, 1'b0);
      broadcast(2, 6'd9, 32'hcafe_f00d, 1'b1);
      broadcast(3, 6'd9, 32'hdead_beef, 1'b1);
      step();
      step();

      alloc(1, 3'd0, 1'b1, 1'b1, 32'h0000_1111, 32'h0000_2222);
      alloc(2, 3'd1, 1'b1, 1'b0, 32'h0000_3333, 32'h0000_000c);
      issueaddr = 3'd1;
      step();
      broadcast(0, 6'd12, 32'h5555_aaaa, 1'b0);
      step();
      alloc(1, 3'd6, 1'b0, 1'b1, 32'h0000_0014, 32'h0000_0001);
      broadcast(1, 6'd20, 32'h7777_0000, 1'b1);   // Lost under the allocation
      step();
      step();

      clearbusy = 1'b1;
      issueaddr = 3'd3;
      step();
      step();

      repeat (RANDOM_CYCLES) begin
         for (int p = 1; p <= 2; p++) begin
            a = $random(seed);
            {go, v1, v2} = $random(seed);
            s1 = $random(seed);
            s2 = $random(seed);
            if (!v1)
               s1[RRF_SEL-1:3] = '0;   // Tags 0 to 7 so broadcasts hit often
            if (!v2)
               s2[RRF_SEL-1:3] = '0;
            if (go && !m_busy[a] && !(p == 2 && we1 && waddr1 == a))
               alloc(p, a, v1, v2, s1, s2);
         end
         a = $random(seed);
         go = $random(seed);
         issueaddr = a;
         clearbusy = go & m_busy[a];
         for (int b = 0; b < CDB_NUM; b++)
            broadcast(b, $random(seed) & 7, $random(seed), $random(seed));
         step();
      end
      step();
      $display("Finished with no errors");
      $finish;
   end

endmodule

// File: design/rs_alu.sv
`timescale 1ns/10ps

module rs_alu
   import rs_alu_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   // Allocation port 1
   input  logic       we1,
   input  ent_sel_t   waddr1,
   input  addr_t      wpc_1,
   input  data_t      wsrc1_1,
   input  data_t      wsrc2_1,
   input  logic       wvalid1_1,
   input  logic       wvalid2_1,
   input  data_t      wimm_1,
   input  rrf_tag_t   wrrftag_1,
   input  logic       wdstval_1,
   input  src_a_sel_t wsrc_a_1,
   input  src_b_sel_t wsrc_b_1,
   input  alu_op_t    walu_op_1,
   // Allocation port 2
   input  logic       we2,
   input  ent_sel_t   waddr2,
   input  addr_t      wpc_2,
   input  data_t      wsrc1_2,
   input  data_t      wsrc2_2,
   input  logic       wvalid1_2,
   input  logic       wvalid2_2,
   input  data_t      wimm_2,
   input  rrf_tag_t   wrrftag_2,
   input  logic       wdstval_2,
   input  src_a_sel_t wsrc_a_2,
   input  src_b_sel_t wsrc_b_2,
   input  alu_op_t    walu_op_2,
   input  logic       clearbusy,
   input  ent_sel_t   issueaddr,
   input  data_t      exrslt [CDB_NUM],
   input  rrf_tag_t   exdst [CDB_NUM],
   input  logic       exvalid [CDB_NUM],
   output ent_vec_t   busyvec,
   output ent_vec_t   ready,
   output data_t      ex_src1,
   output data_t      ex_src2,
   output addr_t      pc,
   output data_t      imm,
   output rrf_tag_t   rrftag,
   output logic       dstval,
   output src_a_sel_t src_a,
   output src_b_sel_t src_b,
   output alu_op_t    alu_op
);

   data_t      ent_src1 [ENT_NUM];
   data_t      ent_src2 [ENT_NUM];
   addr_t      ent_pc [ENT_NUM];
   data_t      ent_imm [ENT_NUM];
   rrf_tag_t   ent_rrftag [ENT_NUM];
   logic       ent_dstval [ENT_NUM];
   src_a_sel_t ent_src_a [ENT_NUM];
   src_b_sel_t ent_src_b [ENT_NUM];
   alu_op_t    ent_alu_op [ENT_NUM];

   rs_busy_tracker u_busy (
      .clk       (clk),
      .reset     (reset),
      .we1       (we1),
      .we2       (we2),
      .waddr1    (waddr1),
      .waddr2    (waddr2),
      .clearbusy (clearbusy),
      .issueaddr (issueaddr),
      .busyvec   (busyvec)
   );

   for (genvar i = 0; i < ENT_NUM; i++) begin : g_ent
      logic sel1;   // Port 1 targets this entry
      logic ent_we;

      assign sel1   = we1 && (waddr1 == ent_sel_t'(i));
      assign ent_we = sel1 || (we2 && (waddr2 == ent_sel_t'(i)));

      rs_alu_entry u_ent (
         .clk     (clk),
         .reset   (reset),
         .busy    (busyvec[i]),
         .we      (ent_we),
         .wpc     (sel1 ? wpc_1 : wpc_2),
         .wsrc1   (sel1 ? wsrc1_1 : wsrc1_2),
         .wsrc2   (sel1 ? wsrc2_1 : wsrc2_2),
         .wvalid1 (sel1 ? wvalid1_1 : wvalid1_2),
         .wvalid2 (sel1 ? wvalid2_1 : wvalid2_2),
         .wimm    (sel1 ? wimm_1 : wimm_2),
         .wrrftag (sel1 ? wrrftag_1 : wrrftag_2),
         .wdstval (sel1 ? wdstval_1 : wdstval_2),
         .wsrc_a  (sel1 ? wsrc_a_1 : wsrc_a_2),
         .wsrc_b  (sel1 ? wsrc_b_1 : wsrc_b_2),
         .walu_op (sel1 ? walu_op_1 : walu_op_2),
         .exrslt  (exrslt),
         .exdst   (exdst),
         .exvalid (exvalid),
         .ex_src1 (ent_src1[i]),
         .ex_src2 (ent_src2[i]),
         .ready   (ready[i]),
         .pc      (ent_pc[i]),
         .imm     (ent_imm[i]),
         .rrftag  (ent_rrftag[i]),
         .dstval  (ent_dstval[i]),
         .src_a   (ent_src_a[i]),
         .src_b   (ent_src_b[i]),
         .alu_op  (ent_alu_op[i])
      );
   end

   // Issue read
   assign ex_src1 = ent_src1[issueaddr];
   assign ex_src2 = ent_src2[issueaddr];
   assign pc      = ent_pc[issueaddr];
   assign imm     = ent_imm[issueaddr];
   assign rrftag  = ent_rrftag[issueaddr];
   assign dstval  = ent_dstval[issueaddr];
   assign src_a   = ent_src_a[issueaddr];
   assign src_b   = ent_src_b[issueaddr];
   assign alu_op  = ent_alu_op[issueaddr];

endmodule

// File: design/rs_busy_tracker.sv
`timescale 1ns/10ps

module rs_busy_tracker
   import rs_alu_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     we1,
   input  logic     we2,
   input  ent_sel_t waddr1,
   input  ent_sel_t waddr2,
   input  logic     clearbusy,
   input  ent_sel_t issueaddr,
   output ent_vec_t busyvec
);

   // Later assignments win, so allocation beats issue on the same entry
   always_ff @(posedge clk) begin
      if (reset) begin
         busyvec <= '0;
      end else begin
         if (clearbusy) begin
            busyvec[issueaddr] <= 1'b0;
         end
         if (we1) begin
            busyvec[waddr1] <= 1'b1;
         end
         if (we2) begin
            busyvec[waddr2] <= 1'b1;
         end
      end
   end

   a_no_dual_write: assert property (@(posedge clk) disable iff (reset)
      !(we1 && we2 && (waddr1 == waddr2)));

   // Allocator must only pick free entries, or one leaving this cycle
   a_alloc1_free: assert property (@(posedge clk) disable iff (reset)
      we1 |-> !busyvec[waddr1] || (clearbusy && (issueaddr == waddr1)));
   a_alloc2_free: assert property (@(posedge clk) disable iff (reset)
      we2 |-> !busyvec[waddr2] || (clearbusy && (issueaddr == waddr2)));

   a_clear_busy: assert property (@(posedge clk) disable iff (reset)
      clearbusy |-> busyvec[issueaddr]);

endmodule

// File: design/rs_alu_entry.sv
`timescale 1ns/10ps

module rs_alu_entry
   import rs_alu_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       busy,
   input  logic       we,
   input  addr_t      wpc,
   input  data_t      wsrc1,
   input  data_t      wsrc2,
   input  logic       wvalid1,
   input  logic       wvalid2,
   input  data_t      wimm,
   input  rrf_tag_t   wrrftag,
   input  logic       wdstval,
   input  src_a_sel_t wsrc_a,
   input  src_b_sel_t wsrc_b,
   input  alu_op_t    walu_op,
   input  data_t      exrslt [CDB_NUM],
   input  rrf_tag_t   exdst [CDB_NUM],
   input  logic       exvalid [CDB_NUM],
   output data_t      ex_src1,
   output data_t      ex_src2,
   output logic       ready,
   output addr_t      pc,
   output data_t      imm,
   output rrf_tag_t   rrftag,
   output logic       dstval,
   output src_a_sel_t src_a,
   output src_b_sel_t src_b,
   output alu_op_t    alu_op
);

   operand_t src1;
   operand_t src2;
   logic     valid1;
   logic     valid2;
   operand_t nextsrc1;
   operand_t nextsrc2;
   logic     nextvalid1;
   logic     nextvalid2;

   assign ready   = busy & valid1 & valid2;
   assign ex_src1 = src1.value;
   assign ex_src2 = src2.value;

   always_ff @(posedge clk) begin
      if (reset) begin
         valid1 <= 1'b0;
         valid2 <= 1'b0;
      end else if (we) begin
         valid1 <= wvalid1;
         valid2 <= wvalid2;
      end else begin
         valid1 <= nextvalid1;
         valid2 <= nextvalid2;
      end
   end

   // A write overrides any broadcast in the same cycle
   always_ff @(posedge clk) begin
      if (we) begin
         src1.value <= wsrc1;
         src2.value <= wsrc2;
         pc         <= wpc;
         imm        <= wimm;
         rrftag     <= wrrftag;
         dstval     <= wdstval;
         src_a      <= wsrc_a;
         src_b      <= wsrc_b;
         alu_op     <= walu_op;
      end else begin
         src1 <= nextsrc1;
         src2 <= nextsrc2;
      end
   end

   operand_wakeup u_wake1 (
      .opr      (src1),
      .opr_rdy  (valid1),
      .exrslt   (exrslt),
      .exdst    (exdst),
      .exvalid  (exvalid),
      .src      (nextsrc1),
      .resolved (nextvalid1)
   );

   operand_wakeup u_wake2 (
      .opr      (src2),
      .opr_rdy  (valid2),
      .exrslt   (exrslt),
      .exdst    (exdst),
      .exvalid  (exvalid),
      .src      (nextsrc2),
      .resolved (nextvalid2)
   );

   // Resolved operands are frozen until the entry is rewritten
   a_src1_stable: assert property (@(posedge clk) disable iff (reset)
      valid1 && !we |=> valid1 && (src1.value == $past(src1.value)));
   a_src2_stable: assert property (@(posedge clk) disable iff (reset)
      valid2 && !we |=> valid2 && (src2.value == $past(src2.value)));

endmodule

// File: design/operand_wakeup.sv
`timescale 1ns/10ps

module operand_wakeup
   import rs_alu_pkg::*;
(
   input  operand_t opr,
   input  logic     opr_rdy,
   input  data_t    exrslt [CDB_NUM],
   input  rrf_tag_t exdst [CDB_NUM],
   input  logic     exvalid [CDB_NUM],
   output operand_t src,
   output logic     resolved
);

   // Search from the top so the lowest-numbered matching bus is taken last
   always_comb begin
      src      = opr;
      resolved = opr_rdy;
      if (!opr_rdy) begin
         for (int i = CDB_NUM - 1; i >= 0; i--) begin
            if (exvalid[i] && (exdst[i] == opr.waiting.tag)) begin
               src.value = exrslt[i];
               resolved  = 1'b1;
            end
         end
      end
   end

endmodule

// File: design/rs_alu_pkg.sv
package rs_alu_pkg;

   localparam int DATA_LEN        = 32;
   localparam int ADDR_LEN        = 32;
   localparam int RRF_SEL         = 6;   // Rename tag width
   localparam int ENT_NUM         = 8;
   localparam int ENT_SEL         = 3;
   localparam int CDB_NUM         = 4;   // Result broadcast buses
   localparam int ALU_OP_WIDTH    = 4;
   localparam int SRC_A_SEL_WIDTH = 2;
   localparam int SRC_B_SEL_WIDTH = 2;

   typedef logic [DATA_LEN-1:0]        data_t;
   typedef logic [ADDR_LEN-1:0]        addr_t;
   typedef logic [RRF_SEL-1:0]         rrf_tag_t;
   typedef logic [ENT_SEL-1:0]         ent_sel_t;
   typedef logic [ENT_NUM-1:0]         ent_vec_t;
   typedef logic [ALU_OP_WIDTH-1:0]    alu_op_t;
   typedef logic [SRC_A_SEL_WIDTH-1:0] src_a_sel_t;
   typedef logic [SRC_B_SEL_WIDTH-1:0] src_b_sel_t;

   // Tag of the producing instruction, kept in the low bits of the operand word
   typedef struct packed {
      logic [DATA_LEN-RRF_SEL-1:0] pad;
      rrf_tag_t                    tag;
   } rrf_wait_t;

   // Operand word holds the value once valid, the producer tag before that
   typedef union packed {
      data_t     value;
      rrf_wait_t waiting;
   } operand_t;

endpackage
